// File: common/display_pkg.sv
`default_nettype none

package display_pkg;

    // widths of the displayed number and of one decimal digit
    localparam int VALUE_BITS = 8;
    localparam int BCD_BITS = 4;
    // the converter produces hundreds, tens and ones, thousands stays zero
    localparam int CONVERT_DIGITS = 3;
    localparam int NUM_VALUES = 4;

    typedef logic [VALUE_BITS-1:0] value_t;
    typedef logic [$clog2(NUM_VALUES)-1:0] value_index_t;
    typedef logic [BCD_BITS-1:0] bcd_digit_t;
    // one enable per digit, leftmost digit in bit 3
    typedef logic [3:0] anode_t;
    // bit 0 is segment a, a one lights the segment
    typedef logic [6:0] segment_t;

    typedef struct packed {
        bcd_digit_t thousands;
        bcd_digit_t hundreds;
        bcd_digit_t tens;
        bcd_digit_t ones;
    } bcd_digits_t;

    // cathode patterns for the digits 0 to 9
    localparam segment_t SEGMENT_TABLE [0:9] = '{
        7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
        7'b1101101, 7'b1111101, 7'b0100111, 7'b1111111, 7'b1101111
    };

    // one second per value and about 2.6 ms per digit at 100 MHz
    localparam int unsigned DWELL_CYCLES_DEFAULT = 100_000_000;
    localparam int unsigned REFRESH_CYCLES_DEFAULT = 262_144;

endpackage

`default_nettype wire

// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef logic [2:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;

    // master to slave, held stable until ack
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        bus_addr_t adr;
        bus_data_t dat_w;
    } wb_request_t;

    // slave to master, dat_r valid while ack is high on a read
    typedef struct packed {
        logic      ack;
        bus_data_t dat_r;
    } wb_response_t;

    // register map, addresses 6 and 7 are unused
    localparam bus_addr_t ADDR_VALUE0 = 3'd0;
    localparam bus_addr_t ADDR_VALUE1 = 3'd1;
    localparam bus_addr_t ADDR_VALUE2 = 3'd2;
    localparam bus_addr_t ADDR_VALUE3 = 3'd3;
    localparam bus_addr_t ADDR_CONTROL = 3'd4;
    localparam bus_addr_t ADDR_STATUS = 3'd5;

endpackage

`default_nettype wire

// File: source/register_bank.sv
`timescale 1ns/100ps
`default_nettype none

module register_bank
    import bus_pkg::*;
    import display_pkg::*;
(
    input  wire clock_100Mhz,
    input  wire reset,
    input  wire wb_request_t wb_req,
    input  wire value_index_t index,
    input  wire done,
    output wb_response_t wb_rsp,
    output value_t [NUM_VALUES-1:0] values,
    output logic enable
);

    // a new transfer is seen while the previous ack is not pending
    logic request;
    bus_data_t read_data;

    assign request = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    // read multiplexer over values, control and status
    always_comb begin
        case (wb_req.adr)
            ADDR_VALUE0: read_data = bus_data_t'(values[0]);
            ADDR_VALUE1: read_data = bus_data_t'(values[1]);
            ADDR_VALUE2: read_data = bus_data_t'(values[2]);
            ADDR_VALUE3: read_data = bus_data_t'(values[3]);
            ADDR_CONTROL: read_data = bus_data_t'(enable);
            // index in bits 1..0, done in bit 2
            ADDR_STATUS: read_data = bus_data_t'({done, index});
            // unused addresses read as zero
            default: read_data = '0;
        endcase
    end

    // ack and write both land on the edge after the request is sampled,
    // so the register holds the new data during the ack cycle
    always_ff @(posedge clock_100Mhz or posedge reset) begin
        if (reset) begin
            wb_rsp.ack <= 1'b0;
            wb_rsp.dat_r <= '0;
            values <= '0;
            enable <= 1'b0;
        end else begin
            // single cycle ack, dropped again on the next edge
            wb_rsp.ack <= request;
            if (request && !wb_req.we) begin
                wb_rsp.dat_r <= read_data;
            end
            if (request && wb_req.we) begin
                case (wb_req.adr)
                    ADDR_VALUE0, ADDR_VALUE1, ADDR_VALUE2, ADDR_VALUE3: begin
                        values[value_index_t'(wb_req.adr)] <= value_t'(wb_req.dat_w);
                    end
                    ADDR_CONTROL: begin
                        enable <= wb_req.dat_w[0];
                    end
                    // status and unused addresses are acked and ignored
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: sequencer/value_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module value_sequencer
    import display_pkg::*;
#(
    parameter int unsigned DWELL_CYCLES = DWELL_CYCLES_DEFAULT
) (
    input  wire clock_100Mhz,
    input  wire reset,
    input  wire enable,
    input  wire value_t [NUM_VALUES-1:0] values,
    output value_t selected_value,
    output value_index_t index,
    output logic done
);

    // counter just wide enough for 0 .. DWELL_CYCLES-1
    localparam int COUNT_BITS = (DWELL_CYCLES > 1) ? $clog2(DWELL_CYCLES) : 1;
    localparam logic [COUNT_BITS-1:0] COUNT_LAST = COUNT_BITS'(DWELL_CYCLES - 1);

    logic [COUNT_BITS-1:0] dwell_count;
    logic dwell_wrap;

    assign dwell_wrap = (dwell_count == COUNT_LAST);

    // counter and index only move while enabled, otherwise both hold
    always_ff @(posedge clock_100Mhz or posedge reset) begin
        if (reset) begin
            dwell_count <= '0;
            index <= '0;
        end else if (enable) begin
            if (dwell_wrap) begin
                dwell_count <= '0;
                // two bit index wraps from 3 back to 0
                index <= index + 1'b1;
            end else begin
                dwell_count <= dwell_count + 1'b1;
            end
        end
    end

    // the value currently on show
    assign selected_value = values[index];

    // high for the whole dwell of the last value
    assign done = enable && (index == value_index_t'(NUM_VALUES - 1));

endmodule

`default_nettype wire

// File: sequencer/bcd_converter.sv
`timescale 1ns/100ps
`default_nettype none

module bcd_converter
    import display_pkg::*;
(
    input  wire clock_100Mhz,
    input  wire reset,
    input  wire value_t selected_value,
    output bcd_digits_t digits
);

    // scratch holds the bcd digits above the binary input
    localparam int SCRATCH_BITS = BCD_BITS * CONVERT_DIGITS + VALUE_BITS;
    localparam int COUNT_BITS = $clog2(VALUE_BITS);
    localparam logic [COUNT_BITS-1:0] LAST_SHIFT = COUNT_BITS'(VALUE_BITS - 1);

    typedef enum logic {
        IDLE,
        SHIFT
    } state_t;

    state_t state;
    value_t last_value;
    logic [COUNT_BITS-1:0] shift_count;
    logic [SCRATCH_BITS-1:0] scratch;
    logic [SCRATCH_BITS-1:0] adjusted;
    logic [SCRATCH_BITS-1:0] step_result;

    // one double-dabble step: add 3 to each digit above 4, then shift left
    always_comb begin
        adjusted = scratch;
        for (int d = 0; d < CONVERT_DIGITS; d++) begin
            if (adjusted[VALUE_BITS + BCD_BITS*d +: BCD_BITS] > 4'd4) begin
                adjusted[VALUE_BITS + BCD_BITS*d +: BCD_BITS] =
                    adjusted[VALUE_BITS + BCD_BITS*d +: BCD_BITS] + 4'd3;
            end
        end
        step_result = {adjusted[SCRATCH_BITS-2:0], 1'b0};
    end

    // capture on a change seen in idle, then 8 shifts; digits update on the 9th edge
    always_ff @(posedge clock_100Mhz or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            last_value <= '0;
            shift_count <= '0;
            digits <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (selected_value != last_value) begin
                        last_value <= selected_value;
                        shift_count <= '0;
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    shift_count <= shift_count + 1'b1;
                    if (shift_count == LAST_SHIFT) begin
                        digits.thousands <= '0;
                        digits.hundreds <= step_result[VALUE_BITS + 2*BCD_BITS +: BCD_BITS];
                        digits.tens <= step_result[VALUE_BITS + BCD_BITS +: BCD_BITS];
                        digits.ones <= step_result[VALUE_BITS +: BCD_BITS];
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // working register, loaded with the new value and shifted in place
    always_ff @(posedge clock_100Mhz) begin
        if (state == IDLE) begin
            scratch <= SCRATCH_BITS'(selected_value);
        end else begin
            scratch <= step_result;
        end
    end

endmodule

`default_nettype wire

// File: scan/digit_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module digit_scanner
    import display_pkg::*;
#(
    parameter int unsigned REFRESH_CYCLES = REFRESH_CYCLES_DEFAULT
) (
    input  wire clock_100Mhz,
    input  wire reset,
    input  wire bcd_digits_t digits,
    output anode_t anode,
    output segment_t segment
);

    // divider counts 0 .. REFRESH_CYCLES-1 per digit slot
    localparam int COUNT_BITS = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;
    localparam logic [COUNT_BITS-1:0] COUNT_LAST = COUNT_BITS'(REFRESH_CYCLES - 1);

    logic [COUNT_BITS-1:0] refresh_count;
    // slot 0 is the leftmost digit
    logic [1:0] slot;
    bcd_digit_t slot_digit;

    always_ff @(posedge clock_100Mhz or posedge reset) begin
        if (reset) begin
            refresh_count <= '0;
            slot <= '0;
        end else if (refresh_count == COUNT_LAST) begin
            refresh_count <= '0;
            slot <= slot + 1'b1;
        end else begin
            refresh_count <= refresh_count + 1'b1;
        end
    end

    // digit shown in the current slot, thousands first
    always_comb begin
        case (slot)
            2'd0: slot_digit = digits.thousands;
            2'd1: slot_digit = digits.hundreds;
            2'd2: slot_digit = digits.tens;
            default: slot_digit = digits.ones;
        endcase
    end

    // both outputs registered, they follow the slot by one cycle
    always_ff @(posedge clock_100Mhz or posedge reset) begin
        if (reset) begin
            anode <= 4'b1000;
            segment <= SEGMENT_TABLE[0];
        end else begin
            // one-hot walk from the left
            anode <= anode_t'(4'b1000) >> slot;
            // codes above nine fall back to the zero pattern
            if (slot_digit > 4'd9) begin
                segment <= SEGMENT_TABLE[0];
            end else begin
                segment <= SEGMENT_TABLE[slot_digit];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/display_top.sv
`timescale 1ns/100ps
`default_nettype none

module display_top
    import bus_pkg::*;
    import display_pkg::*;
#(
    parameter int unsigned DWELL_CYCLES = DWELL_CYCLES_DEFAULT,
    parameter int unsigned REFRESH_CYCLES = REFRESH_CYCLES_DEFAULT
) (
    input  wire clock_100Mhz,
    input  wire reset,
    input  wire wb_request_t wb_req,
    output wb_response_t wb_rsp,
    output anode_t anode,
    output segment_t segment,
    output logic done
);

    // host registers to the sequencer
    value_t [NUM_VALUES-1:0] values;
    logic enable;
    // sequencer to converter, index back to status
    value_t selected_value;
    value_index_t index;
    // converter to scanner
    bcd_digits_t digits;

    register_bank u_register_bank (
        .clock_100Mhz(clock_100Mhz),
        .reset(reset),
        .wb_req(wb_req),
        .index(index),
        .done(done),
        .wb_rsp(wb_rsp),
        .values(values),
        .enable(enable)
    );

    value_sequencer #(
        .DWELL_CYCLES(DWELL_CYCLES)
    ) u_value_sequencer (
        .clock_100Mhz(clock_100Mhz),
        .reset(reset),
        .enable(enable),
        .values(values),
        .selected_value(selected_value),
        .index(index),
        .done(done)
    );

    bcd_converter u_bcd_converter (
        .clock_100Mhz(clock_100Mhz),
        .reset(reset),
        .selected_value(selected_value),
        .digits(digits)
    );

    digit_scanner #(
        .REFRESH_CYCLES(REFRESH_CYCLES)
    ) u_digit_scanner (
        .clock_100Mhz(clock_100Mhz),
        .reset(reset),
        .digits(digits),
        .anode(anode),
        .segment(segment)
    );

endmodule

`default_nettype wire

// File: verification/display_properties.sv
`timescale 1ns/100ps
`default_nettype none

module display_properties
    import bus_pkg::*;
    import display_pkg::*;
(
    input wire clock_100Mhz,
    input wire reset,
    input wire wb_request_t wb_req,
    input wire wb_response_t wb_rsp,
    input wire anode_t anode,
    input wire value_index_t index,
    input wire done
);

    // failures seen per rule
    int ack_length_failures = 0;
    int ack_origin_failures = 0;
    int anode_failures = 0;
    int status_failures = 0;
    int failure_count;

    assign failure_count = ack_length_failures + ack_origin_failures
                         + anode_failures + status_failures;

    // single cycle ack
    ack_single_cycle: assert property (
        @(posedge clock_100Mhz) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else begin
        $error("ack stayed high for two cycles");
        ack_length_failures++;
    end

    // ack only after a cycle with cyc and stb high and no ack pending
    ack_after_request: assert property (
        @(posedge clock_100Mhz) disable iff (reset)
        wb_rsp.ack |-> $past(wb_req.cyc) && $past(wb_req.stb) && !$past(wb_rsp.ack)
    ) else begin
        $error("ack without a preceding request");
        ack_origin_failures++;
    end

    // exactly one digit lit at any time
    anode_one_hot: assert property (
        @(posedge clock_100Mhz) disable iff (reset)
        $onehot(anode)
    ) else begin
        $error("anode is not one-hot");
        anode_failures++;
    end

    // status read data was sampled on the request edge
    // and shows done only together with the last index
    status_done_on_last_value: assert property (
        @(posedge clock_100Mhz) disable iff (reset)
        wb_rsp.ack && !$past(wb_req.we) && $past(wb_req.adr) == ADDR_STATUS
        |-> wb_rsp.dat_r[2:0] == {$past(done), $past(index)}
            && (!wb_rsp.dat_r[2] || wb_rsp.dat_r[1:0] == value_index_t'(NUM_VALUES - 1))
    ) else begin
        $error("status read shows a wrong index or a done bit away from index 3");
        status_failures++;
    end

endmodule

bind display_top display_properties u_display_properties (
    .clock_100Mhz(clock_100Mhz),
    .reset(reset),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp),
    .anode(anode),
    .index(index),
    .done(done)
);

`default_nettype wire

// File: verification/display_tb.sv
`timescale 1ns/100ps
`default_nettype none

module display_tb
    import bus_pkg::*;
    import display_pkg::*;
();

    // short dwell and refresh so a full rotation fits in a few hundred cycles
    localparam int DWELL = 64;
    localparam int REFRESH = 4;
    localparam int NUM_LINES = 4;
    // four values, then hundreds, tens and ones of each value
    localparam int LINE_WORDS = 16;
    // reset, registers, one rotation per data line, freeze, rewrite
    localparam int TEST_COUNT = NUM_LINES + 4;
    localparam int TIMEOUT_CYCLES = TEST_COUNT * 5 * DWELL + 200;
    // one pass over all four anodes
    localparam int SCAN_CYCLES = 4 * REFRESH;
    localparam int SETTLE_CYCLES = 16;

    logic clock_100Mhz;
    logic reset;
    wb_request_t wb_req;
    wb_response_t wb_rsp;
    anode_t anode;
    segment_t segment;
    logic done;

    logic [7:0] test_mem [0:NUM_LINES*LINE_WORDS-1];
    logic [31:0] random_state;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int test_number = 0;
    int failed_tests = 0;
    int test_start_errors = 0;
    // result of the last scan, one pattern per slot and a mask of slots seen
    segment_t seen_segment [0:3];
    logic [3:0] seen_mask;

    display_top #(
        .DWELL_CYCLES(DWELL),
        .REFRESH_CYCLES(REFRESH)
    ) u_display_top (
        .clock_100Mhz(clock_100Mhz),
        .reset(reset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .anode(anode),
        .segment(segment),
        .done(done)
    );

    initial begin
        clock_100Mhz = 1'b0;
        forever #5 clock_100Mhz = ~clock_100Mhz;
    end

    // hard stop in case a handshake never completes
    always @(posedge clock_100Mhz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // xorshift step for the idle gaps between transfers
    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reference cathode patterns, bit 0 is segment a
    function automatic segment_t digit_pattern(input logic [3:0] digit);
        case (digit)
            4'd1: return 7'h06;
            4'd2: return 7'h5b;
            4'd3: return 7'h4f;
            4'd4: return 7'h66;
            4'd5: return 7'h6d;
            4'd6: return 7'h7d;
            4'd7: return 7'h27;
            4'd8: return 7'h7f;
            4'd9: return 7'h6f;
            default: return 7'h3f;
        endcase
    endfunction

    // slot 0 is thousands and always zero, slots 1..3 come from the data line
    function automatic segment_t expected_segment(input int line, input int value_slot,
                                                  input int scan_slot);
        if (scan_slot == 0) begin
            return digit_pattern(4'd0);
        end
        return digit_pattern(test_mem[line*LINE_WORDS + 4 + 3*value_slot + scan_slot - 1][3:0]);
    endfunction

    function automatic logic display_matches(input int line, input int value_slot);
        logic ok;
        ok = (seen_mask == 4'hf);
        for (int s = 0; s < 4; s++) begin
            if (seen_segment[s] != expected_segment(line, value_slot, s)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_condition(input logic ok, input string message);
        check_count++;
        assert (ok) else begin
            $display("%s", message);
            error_count++;
        end
    endtask

    task automatic start_test();
        test_start_errors = error_count;
    endtask

    // one line per finished test
    task automatic report_test(input string name);
        test_number++;
        if (error_count == test_start_errors) begin
            $display("test %0d %s: ok", test_number, name);
        end else begin
            $display("test %0d %s: failed", test_number, name);
            failed_tests++;
        end
    endtask

    task automatic idle_gap();
        int gap;
        random_state = next_random(random_state);
        gap = int'(random_state[1:0]);
        repeat (gap) @(negedge clock_100Mhz);
    endtask

    // classic cycle, request held from a falling edge until ack is seen
    task automatic bus_transfer(input logic we, input bus_addr_t adr, input bus_data_t dat_w,
                                output bus_data_t dat_r);
        idle_gap();
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat_w};
        do begin
            @(negedge clock_100Mhz);
        end while (!wb_rsp.ack);
        dat_r = wb_rsp.dat_r;
        wb_req = '0;
    endtask

    task automatic bus_write(input bus_addr_t adr, input bus_data_t data);
        bus_data_t unused;
        bus_transfer(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input bus_addr_t adr, output bus_data_t data);
        bus_transfer(1'b0, adr, 8'h00, data);
    endtask

    // status read with the done bit checked against the index
    task automatic read_status(input logic enabled, output logic [7:0] status);
        bus_read(ADDR_STATUS, status);
        check_value("status[7:3]", 32'(status[7:3]), 32'd0);
        check_value("status.done", 32'(status[2]), 32'(enabled && status[1:0] == 2'd3));
    endtask

    // poll until the index moves on, it may only step by one
    task automatic wait_index_change(input logic [1:0] old_index, output logic [7:0] status);
        logic [1:0] next_index;
        next_index = old_index + 2'd1;
        do begin
            read_status(1'b1, status);
        end while (status[1:0] == old_index);
        check_value("status.index", 32'(status[1:0]), 32'(next_index));
    endtask

    // record the segment pattern shown under each anode for one full scan
    task automatic sample_display();
        seen_mask = '0;
        repeat (SCAN_CYCLES) begin
            @(negedge clock_100Mhz);
            check_condition($onehot(anode), "anode is not one-hot during a scan");
            for (int s = 0; s < 4; s++) begin
                if (anode == (4'b1000 >> s)) begin
                    seen_mask[s] = 1'b1;
                    seen_segment[s] = segment;
                end
            end
        end
    endtask

    task automatic check_slot(input int s, input segment_t expected);
        check_condition(seen_mask[s], $sformatf("anode slot %0d was never lit in a scan", s));
        check_value($sformatf("segment[%0d]", s), 32'(seen_segment[s]), 32'(expected));
    endtask

    task automatic check_display(input int line, input int value_slot);
        for (int s = 0; s < 4; s++) begin
            check_slot(s, expected_segment(line, value_slot, s));
        end
    endtask

    initial begin
        logic [7:0] data;
        logic [7:0] status;
        logic [1:0] held_index;
        logic matched;
        int elapsed;
        int property_failures;
        wb_req = '0;
        reset = 1'b1;
        random_state = 32'd54207;
        $readmemh("verification/display_testdata.txt", test_mem);
        repeat (3) @(negedge clock_100Mhz);
        reset = 1'b0;

        // reset state, blank registers show zero on every digit
        start_test();
        check_value("anode", 32'(anode), 32'h8);
        check_value("done", 32'(done), 32'd0);
        sample_display();
        for (int s = 0; s < 4; s++) begin
            check_slot(s, digit_pattern(4'd0));
        end
        bus_read(ADDR_STATUS, data);
        check_value("status", 32'(data), 32'd0);
        report_test("reset state");

        // read back of every writable register, status and unused space ignored
        start_test();
        for (int v = 0; v < 4; v++) begin
            bus_write(bus_addr_t'(v), test_mem[LINE_WORDS + v]);
        end
        for (int v = 0; v < 4; v++) begin
            bus_read(bus_addr_t'(v), data);
            check_value($sformatf("value%0d", v), 32'(data), 32'(test_mem[LINE_WORDS + v]));
        end
        bus_write(ADDR_CONTROL, 8'h01);
        bus_read(ADDR_CONTROL, data);
        check_value("control", 32'(data), 32'h01);
        bus_write(ADDR_CONTROL, 8'h00);
        bus_read(ADDR_CONTROL, data);
        check_value("control", 32'(data), 32'h00);
        bus_write(ADDR_STATUS, 8'hff);
        bus_read(ADDR_STATUS, data);
        check_value("status", 32'(data), 32'd0);
        bus_write(3'd6, 8'h5a);
        bus_read(3'd6, data);
        check_value("unused register", 32'(data), 32'd0);
        report_test("register access");

        // one full rotation per data line, display checked in every dwell
        for (int line = 0; line < NUM_LINES; line++) begin
            start_test();
            for (int v = 0; v < 4; v++) begin
                bus_write(bus_addr_t'(v), test_mem[line*LINE_WORDS + v]);
            end
            if (line == 0) begin
                bus_write(ADDR_CONTROL, 8'h01);
            end
            read_status(1'b1, status);
            wait_index_change(status[1:0], status);
            repeat (4) begin
                held_index = status[1:0];
                repeat (SETTLE_CYCLES) @(negedge clock_100Mhz);
                sample_display();
                check_display(line, int'(held_index));
                check_value("done", 32'(done), 32'(held_index == 2'd3));
                read_status(1'b1, status);
                check_value("status.index", 32'(status[1:0]), 32'(held_index));
                wait_index_change(held_index, status);
            end
            report_test($sformatf("rotation of data line %0d", line));
        end

        // disabled sequencer holds index and digits, then resumes in place
        start_test();
        bus_write(ADDR_CONTROL, 8'h00);
        read_status(1'b0, status);
        held_index = status[1:0];
        repeat (SETTLE_CYCLES) @(negedge clock_100Mhz);
        sample_display();
        check_display(NUM_LINES - 1, int'(held_index));
        repeat (2 * DWELL) @(negedge clock_100Mhz);
        read_status(1'b0, status);
        check_value("status.index", 32'(status[1:0]), 32'(held_index));
        sample_display();
        check_display(NUM_LINES - 1, int'(held_index));
        bus_write(ADDR_CONTROL, 8'h01);
        read_status(1'b1, status);
        check_value("status.index", 32'(status[1:0]), 32'(held_index));
        wait_index_change(held_index, status);
        report_test("freeze and resume");

        // the index just changed, so most of the dwell is left for the rewrite
        start_test();
        held_index = status[1:0];
        bus_write(bus_addr_t'(held_index), test_mem[held_index]);
        elapsed = 0;
        do begin
            sample_display();
            elapsed += SCAN_CYCLES;
            matched = display_matches(0, int'(held_index));
        end while (!matched && elapsed + SCAN_CYCLES <= DWELL + 10);
        check_condition(matched, "rewritten value not shown within one dwell plus 10 cycles");
        check_display(0, int'(held_index));
        read_status(1'b1, status);
        check_value("status.index", 32'(status[1:0]), 32'(held_index));
        report_test("rewrite of the shown value");

        property_failures = u_display_top.u_display_properties.failure_count;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_number, failed_tests, check_count, error_count, property_failures);
        if (error_count == 0 && failed_tests == 0 && property_failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/display_testdata.txt
// columns: value0 value1 value2 value3, then hundreds tens ones of value0 .. value3
// all entries in hex, one test per line
00 09 0a 63 0 0 0 0 0 9 0 1 0 0 9 9
64 7b c8 ff 1 0 0 1 2 3 2 0 0 2 5 5
2a 80 e7 37 0 4 2 1 2 8 2 3 1 0 5 5
05 4d 96 f5 0 0 5 0 7 7 1 5 0 2 4 5

// File: tb.f
common/display_pkg.sv
common/bus_pkg.sv
source/register_bank.sv
sequencer/value_sequencer.sv
sequencer/bcd_converter.sv
scan/digit_scanner.sv
source/display_top.sv
verification/display_properties.sv
verification/display_tb.sv

// File: Makefile
# Verilator build, run and lint of the display controller testbench

SOURCES = $(wildcard common/*.sv source/*.sv sequencer/*.sv scan/*.sv verification/*.sv)

all: run

obj_dir/Vdisplay_tb: tb.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module display_tb -o Vdisplay_tb

run: obj_dir/Vdisplay_tb verification/display_testdata.txt
	./obj_dir/Vdisplay_tb | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module display_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
